// File: src/spi_flash_pkg.sv
package spi_flash_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int OPC_W = 8;

  // Opcode, widest address and widest data word, sent MSB first
  localparam int TX_W = OPC_W + ADDR_W + DATA_W;

  // Two SCLK edges per single-lane bit: cmd + 4-byte addr + max dummy + max data
  localparam int MAX_EDGES = 2 * (OPC_W + ADDR_W + 15 + DATA_W);

  typedef enum logic [1:0] {
    LANE_SINGLE = 2'd0,
    LANE_DUAL   = 2'd1,
    LANE_QUAD   = 2'd2
  } lane_w_e;

  typedef enum logic [1:0] {
    DIR_NONE  = 2'd0,
    DIR_WRITE = 2'd1,
    DIR_READ  = 2'd2
  } spi_dir_e;

  typedef struct packed {
    logic [OPC_W-1:0]  opcode;
    logic [ADDR_W-1:0] addr;
    logic              addr4b;
    logic              has_addr;
    logic [3:0]        dummy;
    logic [5:0]        nbits;
    spi_dir_e          dir;
    lane_w_e           cmd_lanes;
    lane_w_e           addr_lanes;
    lane_w_e           data_lanes;
    logic [DATA_W-1:0] wdata;
  } spi_req_t;

  // Read data right-aligned in rdata
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic [OPC_W-1:0]  opcode;
  } spi_rsp_t;

endpackage

// File: src/spi_queue.sv
`timescale 1ns/1ps

module spi_queue #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready_o  = (count != CW'(DEPTH));
  assign out_valid_o = (count != '0);
  assign out_data_o  = mem[rd_ptr];
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // An accepted write always lands in a free slot
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    push |-> (count < CW'(DEPTH)) && ((count == '0) == (wr_ptr == rd_ptr)));

endmodule

// File: src/sclk_gen.sv
`timescale 1ns/1ps

module sclk_gen #(
  parameter int CLKS_PER_HALF_SCLK = 2,
  parameter int CPOL = 1,
  parameter int CPHA = 1
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       en_i,
  input  logic       start_i,
  input  logic [7:0] edges_i,
  output logic       sclk_o,
  output logic       lead_o,
  output logic       trail_o,
  output logic       done_o
);

  localparam int DW = (CLKS_PER_HALF_SCLK > 1) ? $clog2(CLKS_PER_HALF_SCLK) : 1;
  localparam int EW = $clog2(spi_flash_pkg::MAX_EDGES + 1);

  logic [DW-1:0] div_cnt;
  logic [EW-1:0] edge_cnt;
  logic          sclk_q;
  logic          tick;

  // Toggle at the end of each half period until the edge budget is spent
  assign tick = en_i && (edge_cnt != edges_i) &&
                (div_cnt == DW'(CLKS_PER_HALF_SCLK - 1));

  // Even edge count means the next toggle leaves the idle level
  assign lead_o  = tick && !edge_cnt[0];
  assign trail_o = tick && edge_cnt[0];
  assign sclk_o  = sclk_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      div_cnt  <= '0;
      edge_cnt <= '0;
      sclk_q   <= 1'(CPOL);
      done_o   <= 1'b0;
    end else begin
      done_o <= tick && (edge_cnt == edges_i - 8'd1);
      if (start_i) begin
        div_cnt  <= '0;
        edge_cnt <= '0;
        sclk_q   <= 1'(CPOL);
      end else begin
        if (en_i) begin
          div_cnt <= (div_cnt == DW'(CLKS_PER_HALF_SCLK - 1)) ? '0 : div_cnt + 1'b1;
        end
        if (tick) begin
          sclk_q   <= ~sclk_q;
          edge_cnt <= edge_cnt + 1'b1;
        end
      end
    end
  end

  // Leading edge leaves the idle level, trailing edge returns to it
  a_one_edge: assert property (@(posedge clk_i) disable iff (rst_i)
    (lead_o || trail_o) |-> (lead_o != trail_o) && (lead_o == (sclk_q == 1'(CPOL))));

  a_edge_budget: assert property (@(posedge clk_i) disable iff (rst_i)
    en_i |-> !edges_i[0] && (edges_i <= spi_flash_pkg::MAX_EDGES));

endmodule

// File: src/frame_planner.sv
`timescale 1ns/1ps

module frame_planner (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             start_i,
  input  spi_flash_pkg::spi_req_t          req_i,
  output logic                             done_o,
  output logic [spi_flash_pkg::TX_W-1:0]   txstr_o,
  output logic [7:0]                       cmd_end_o,
  output logic [7:0]                       addr_end_o,
  output logic [7:0]                       dummy_end_o,
  output logic [7:0]                       data_end_o,
  output logic [7:0]                       edges_o
);

  logic [spi_flash_pkg::TX_W-1:0] tx_c;
  logic [31:0]                    wleft;
  logic [5:0]                     cmd_bt;
  logic [5:0]                     addr_bt;
  logic [5:0]                     data_bt;
  logic [3:0]                     dummy_q;
  logic                           s1_valid;
  logic [7:0]                     cmd_m;
  logic [7:0]                     addr_m;
  logic [7:0]                     dummy_m;
  logic [7:0]                     data_m;

  function automatic logic [5:0] to_bit_times(input logic [5:0] bits,
                                              input spi_flash_pkg::lane_w_e lanes);
    case (lanes)
      spi_flash_pkg::LANE_DUAL: return bits >> 1;
      spi_flash_pkg::LANE_QUAD: return bits >> 2;
      default:                  return bits;
    endcase
  endfunction

  // Write data sits right-aligned in the request, move it to the top
  always_comb begin
    wleft = req_i.wdata << (7'd32 - {1'b0, req_i.nbits});
    if (!req_i.has_addr) begin
      tx_c = {req_i.opcode, wleft, 32'h0};
    end else if (req_i.addr4b) begin
      tx_c = {req_i.opcode, req_i.addr, wleft};
    end else begin
      tx_c = {req_i.opcode, req_i.addr[23:0], wleft, 8'h00};
    end
  end

  assign cmd_m   = {2'b00, cmd_bt};
  assign addr_m  = cmd_m + {2'b00, addr_bt};
  assign dummy_m = addr_m + {4'h0, dummy_q};
  assign data_m  = dummy_m + {2'b00, data_bt};

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      txstr_o <= tx_c;
      cmd_bt  <= to_bit_times(6'd8, req_i.cmd_lanes);
      addr_bt <= !req_i.has_addr ? 6'd0 :
                 to_bit_times(req_i.addr4b ? 6'd32 : 6'd24, req_i.addr_lanes);
      data_bt <= (req_i.dir == spi_flash_pkg::DIR_NONE) ? 6'd0 :
                 to_bit_times(req_i.nbits, req_i.data_lanes);
      dummy_q <= req_i.dummy;
    end
    if (s1_valid) begin
      cmd_end_o   <= cmd_m;
      addr_end_o  <= addr_m;
      dummy_end_o <= dummy_m;
      data_end_o  <= data_m;
      edges_o     <= {data_m[6:0], 1'b0};
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      s1_valid <= start_i;
      done_o   <= s1_valid;
    end
  end

endmodule

// File: src/lane_shifter.sv
`timescale 1ns/1ps

module lane_shifter #(
  parameter int CPHA = 1
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           load_i,
  input  logic                           lead_i,
  input  logic                           trail_i,
  input  logic [spi_flash_pkg::TX_W-1:0] txstr_i,
  input  logic [7:0]                     cmd_end_i,
  input  logic [7:0]                     addr_end_i,
  input  logic [7:0]                     dummy_end_i,
  input  logic [7:0]                     data_end_i,
  input  spi_flash_pkg::spi_req_t        req_i,
  input  logic [3:0]                     dq_i,
  output logic [3:0]                     dq_o,
  output logic [3:0]                     dq_oe_o,
  output logic [31:0]                    rdata_o
);

  localparam int TW = spi_flash_pkg::TX_W;

  logic [TW-1:0]          shreg;
  logic [7:0]             tx_bt;
  logic [7:0]             rx_bt;
  logic                   active;
  logic                   primed;
  logic                   last_q;
  logic                   launch;
  logic                   sample;
  logic                   tx_shift;
  logic                   tx_dummy;
  logic                   tx_rd_data;
  logic                   rx_fire;
  spi_flash_pkg::lane_w_e tx_lanes;
  spi_flash_pkg::lane_w_e rx_lanes;

  function automatic spi_flash_pkg::lane_w_e phase_lanes(input logic [7:0] bt);
    if (bt < cmd_end_i) begin
      return req_i.cmd_lanes;
    end
    if (bt < addr_end_i) begin
      return req_i.addr_lanes;
    end
    return req_i.data_lanes;
  endfunction

  assign launch = (CPHA == 1) ? lead_i : trail_i;
  assign sample = (CPHA == 1) ? trail_i : lead_i;

  assign tx_lanes   = phase_lanes(tx_bt);
  assign rx_lanes   = phase_lanes(rx_bt);
  assign tx_dummy   = (tx_bt >= addr_end_i) && (tx_bt < dummy_end_i);
  assign tx_rd_data = (req_i.dir == spi_flash_pkg::DIR_READ) && (tx_bt >= dummy_end_i);
  assign tx_shift   = active && primed && launch;
  assign rx_fire    = active && sample && (req_i.dir == spi_flash_pkg::DIR_READ) &&
                      (rx_bt >= dummy_end_i) && (rx_bt < data_end_i);

  // Idle WP# and HOLD# levels on DQ2/DQ3
  always_comb begin
    dq_o = 4'b1100;
    case (tx_lanes)
      spi_flash_pkg::LANE_QUAD: dq_o = shreg[TW-1 -: 4];
      spi_flash_pkg::LANE_DUAL: dq_o[1:0] = shreg[TW-1 -: 2];
      default:                  dq_o[0] = shreg[TW-1];
    endcase
  end

  // Released during dummy cycles and read data
  always_comb begin
    if (!active) begin
      dq_oe_o = 4'b0001;
    end else if (tx_dummy || tx_rd_data) begin
      dq_oe_o = 4'b0000;
    end else begin
      case (tx_lanes)
        spi_flash_pkg::LANE_QUAD: dq_oe_o = 4'b1111;
        spi_flash_pkg::LANE_DUAL: dq_oe_o = 4'b0011;
        default:                  dq_oe_o = 4'b0001;
      endcase
    end
  end

  // Dummy bit-times have no bits in the transmit string
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      shreg   <= txstr_i;
      rdata_o <= '0;
    end else begin
      if (tx_shift && !tx_dummy) begin
        case (tx_lanes)
          spi_flash_pkg::LANE_QUAD: shreg <= shreg << 4;
          spi_flash_pkg::LANE_DUAL: shreg <= shreg << 2;
          default:                  shreg <= shreg << 1;
        endcase
      end
      if (rx_fire) begin
        case (rx_lanes)
          spi_flash_pkg::LANE_QUAD: rdata_o <= {rdata_o[27:0], dq_i};
          spi_flash_pkg::LANE_DUAL: rdata_o <= {rdata_o[29:0], dq_i[1:0]};
          default:                  rdata_o <= {rdata_o[30:0], dq_i[1]};
        endcase
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      tx_bt  <= '0;
      rx_bt  <= '0;
      active <= 1'b0;
      primed <= 1'b0;
      last_q <= 1'b0;
    end else begin
      last_q <= active && sample && (rx_bt == data_end_i - 8'd1);
      if (load_i) begin
        tx_bt  <= '0;
        rx_bt  <= '0;
        active <= 1'b1;
        // Mode 0 presents bit 0 before the first edge
        primed <= (CPHA != 1);
      end else begin
        if (active && launch) begin
          primed <= 1'b1;
        end
        if (tx_shift) begin
          tx_bt <= tx_bt + 8'd1;
        end
        if (active && sample) begin
          rx_bt <= rx_bt + 8'd1;
        end
        if (last_q) begin
          active <= 1'b0;
        end
      end
    end
  end

  a_released_on_read: assert property (@(posedge clk_i) disable iff (rst_i)
    rx_fire |-> (dq_oe_o == 4'b0000));

endmodule

// File: src/spi_flash_master.sv
`timescale 1ns/1ps

module spi_flash_master #(
  parameter int CLKS_PER_HALF_SCLK = 2,
  parameter int CPOL = 1,
  parameter int CPHA = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  spi_flash_pkg::spi_req_t req_i,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output spi_flash_pkg::spi_rsp_t rsp_o,
  output logic                    sclk_o,
  output logic                    ss_n_o,
  input  logic [3:0]              dq_i,
  output logic [3:0]              dq_o,
  output logic [3:0]              dq_oe_o
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    TRANSFER
  } state_e;

  state_e                         state;
  spi_flash_pkg::spi_req_t        req_q;
  spi_flash_pkg::spi_rsp_t        rsp_q;
  logic                           rsp_valid_q;
  logic                           ss_n_q;
  logic                           plan_start;
  logic                           sclk_start;
  logic                           req_fire;
  logic                           plan_done;
  logic                           sclk_done;
  logic                           lead;
  logic                           trail;
  logic [spi_flash_pkg::TX_W-1:0] txstr;
  logic [7:0]                     cmd_end;
  logic [7:0]                     addr_end;
  logic [7:0]                     dummy_end;
  logic [7:0]                     data_end;
  logic [7:0]                     edges;
  logic [31:0]                    rdata;

  // A free response slot is reserved before a frame starts
  assign req_ready_o = (state == IDLE) && rsp_ready_i && !rsp_valid_q;
  assign req_fire    = req_valid_i && req_ready_o;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign ss_n_o      = ss_n_q;

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      req_q <= req_i;
    end
    if (sclk_done) begin
      rsp_q.rdata  <= rdata;
      rsp_q.opcode <= req_q.opcode;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state       <= IDLE;
      ss_n_q      <= 1'b1;
      plan_start  <= 1'b0;
      sclk_start  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      plan_start  <= 1'b0;
      sclk_start  <= 1'b0;
      rsp_valid_q <= 1'b0;
      case (state)
        IDLE: begin
          if (req_fire) begin
            plan_start <= 1'b1;
            state      <= SETUP;
          end
        end
        SETUP: begin
          if (plan_done) begin
            sclk_start <= 1'b1;
            state      <= TRANSFER;
          end
        end
        TRANSFER: begin
          if (sclk_done) begin
            ss_n_q      <= 1'b1;
            rsp_valid_q <= 1'b1;
            state       <= IDLE;
          end else begin
            ss_n_q <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  sclk_gen #(
    .CLKS_PER_HALF_SCLK(CLKS_PER_HALF_SCLK),
    .CPOL(CPOL),
    .CPHA(CPHA)
  ) u_sclk_gen (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .en_i(!ss_n_q),
    .start_i(sclk_start),
    .edges_i(edges),
    .sclk_o(sclk_o),
    .lead_o(lead),
    .trail_o(trail),
    .done_o(sclk_done)
  );

  frame_planner u_planner (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .start_i(plan_start),
    .req_i(req_q),
    .done_o(plan_done),
    .txstr_o(txstr),
    .cmd_end_o(cmd_end),
    .addr_end_o(addr_end),
    .dummy_end_o(dummy_end),
    .data_end_o(data_end),
    .edges_o(edges)
  );

  lane_shifter #(
    .CPHA(CPHA)
  ) u_shifter (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .load_i(plan_done),
    .lead_i(lead),
    .trail_i(trail),
    .txstr_i(txstr),
    .cmd_end_i(cmd_end),
    .addr_end_i(addr_end),
    .dummy_end_i(dummy_end),
    .data_end_i(data_end),
    .req_i(req_q),
    .dq_i(dq_i),
    .dq_o(dq_o),
    .dq_oe_o(dq_oe_o),
    .rdata_o(rdata)
  );

  a_sclk_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    ss_n_o |-> (sclk_o == 1'(CPOL)));

  // Accept, plan in two cycles, then select the device
  a_ss_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    req_fire |-> ##5 $fell(ss_n_o));

endmodule

// File: src/spi_flash_top.sv
`timescale 1ns/1ps

module spi_flash_top #(
  parameter int CLKS_PER_HALF_SCLK = 2,
  parameter int CPOL = 1,
  parameter int CPHA = 1,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  spi_flash_pkg::spi_req_t req_i,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output spi_flash_pkg::spi_rsp_t rsp_o,
  output logic                    sclk_o,
  output logic                    ss_n_o,
  input  logic [3:0]              dq_i,
  output logic [3:0]              dq_o,
  output logic [3:0]              dq_oe_o
);

  logic                    mreq_valid;
  logic                    mreq_ready;
  spi_flash_pkg::spi_req_t mreq;
  logic                    mrsp_valid;
  logic                    mrsp_ready;
  spi_flash_pkg::spi_rsp_t mrsp;

  spi_queue #(
    .T(spi_flash_pkg::spi_req_t),
    .DEPTH(QUEUE_DEPTH)
  ) u_req_queue (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .in_valid_i(req_valid_i),
    .in_ready_o(req_ready_o),
    .in_data_i(req_i),
    .out_valid_o(mreq_valid),
    .out_ready_i(mreq_ready),
    .out_data_o(mreq)
  );

  spi_flash_master #(
    .CLKS_PER_HALF_SCLK(CLKS_PER_HALF_SCLK),
    .CPOL(CPOL),
    .CPHA(CPHA)
  ) u_master (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .req_valid_i(mreq_valid),
    .req_ready_o(mreq_ready),
    .req_i(mreq),
    .rsp_valid_o(mrsp_valid),
    .rsp_ready_i(mrsp_ready),
    .rsp_o(mrsp),
    .sclk_o(sclk_o),
    .ss_n_o(ss_n_o),
    .dq_i(dq_i),
    .dq_o(dq_o),
    .dq_oe_o(dq_oe_o)
  );

  spi_queue #(
    .T(spi_flash_pkg::spi_rsp_t),
    .DEPTH(QUEUE_DEPTH)
  ) u_rsp_queue (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .in_valid_i(mrsp_valid),
    .in_ready_o(mrsp_ready),
    .in_data_i(mrsp),
    .out_valid_o(rsp_valid_o),
    .out_ready_i(rsp_ready_i),
    .out_data_o(rsp_o)
  );

endmodule

// File: dv/flash_model.sv
`timescale 1ns/1ps

module flash_model #(
  parameter int       MEM_BYTES = 256,
  parameter bit [7:0] FILL_XOR  = 8'hA5
) (
  input  logic       sclk_i,
  input  logic       ss_n_i,
  input  logic [3:0] host_dq_i,
  input  logic [3:0] host_oe_i,
  output logic [3:0] line_o
);

  localparam int AW = $clog2(MEM_BYTES);

  logic [7:0]  mem [MEM_BYTES];
  logic [3:0]  drv;
  logic [3:0]  drv_oe;
  logic [7:0]  opcode;
  logic [31:0] addr;
  logic [7:0]  wbyte;
  logic [7:0]  rbyte;
  logic        is_read;
  logic        is_write;
  int          bt;
  int          abits;
  int          dummy;
  int          lanes;
  int          wcnt;
  int          rcnt;

  // Host drive wins, then the flash drive, then the pull-up
  assign line_o = (host_oe_i & host_dq_i) | (~host_oe_i & drv_oe & drv) |
                  (~host_oe_i & ~drv_oe);

  initial begin
    int i;
    for (i = 0; i < MEM_BYTES; i++) begin
      mem[i] = i[7:0] ^ FILL_XOR;
    end
    drv      = '0;
    drv_oe   = '0;
    opcode   = '0;
    addr     = '0;
    is_read  = 1'b0;
    is_write = 1'b0;
    bt       = 0;
    abits    = 24;
    dummy    = 0;
    lanes    = 1;
  end

  always @(negedge ss_n_i) begin
    bt       = 0;
    wcnt     = 0;
    rcnt     = 0;
    addr     = '0;
    is_read  = 1'b0;
    is_write = 1'b0;
    drv_oe   = '0;
  end

  always @(posedge ss_n_i) begin
    drv_oe = '0;
  end

  // Command and address on DQ0, program data on one or four lanes
  always @(posedge sclk_i) begin
    if (ss_n_i === 1'b0) begin
      if (bt < 8) begin
        opcode = {opcode[6:0], line_o[0]};
      end else if (bt < 8 + abits) begin
        addr = {addr[30:0], line_o[0]};
      end else if (is_write && bt >= 8 + abits + dummy) begin
        if (lanes == 4) begin
          wbyte = {wbyte[3:0], line_o};
        end else begin
          wbyte = {wbyte[6:0], line_o[0]};
        end
        wcnt += lanes;
        if (wcnt == 8) begin
          mem[addr[AW-1:0]] = wbyte;
          addr = addr + 1;
          wcnt = 0;
        end
      end
      bt++;
      if (bt == 8) begin
        abits    = (opcode == 8'h13) ? 32 : 24;
        dummy    = (opcode == 8'h3B || opcode == 8'h6B) ? 8 : 0;
        lanes    = (opcode == 8'h3B) ? 2 : (opcode == 8'h6B || opcode == 8'h32) ? 4 : 1;
        is_read  = opcode inside {8'h03, 8'h13, 8'h3B, 8'h6B};
        is_write = opcode inside {8'h02, 8'h32};
      end
    end
  end

  // Read data changes on the falling edge
  always @(negedge sclk_i) begin
    if (ss_n_i === 1'b0 && is_read && bt >= 8 + abits + dummy) begin
      if (rcnt == 0) begin
        rbyte = mem[addr[AW-1:0]];
        addr  = addr + 1;
      end
      case (lanes)
        4: begin
          drv    = rbyte[7:4];
          drv_oe = 4'b1111;
        end
        2: begin
          drv[1:0] = rbyte[7:6];
          drv_oe   = 4'b0011;
        end
        default: begin
          drv[1] = rbyte[7];
          drv_oe = 4'b0010;
        end
      endcase
      rbyte = rbyte << lanes;
      rcnt  = (rcnt + lanes) % 8;
    end
  end

endmodule

// File: dv/tb_spi_flash.sv
`timescale 1ns/1ps

module tb_spi_flash;

  localparam int       CLKS_PER_HALF_SCLK = 2;
  localparam int       CPOL = 1;
  localparam int       CPHA = 1;
  localparam int       QUEUE_DEPTH = 4;
  localparam int       MEM_BYTES = 256;
  localparam bit [7:0] FILL_XOR = 8'hA5;
  // Longest frame is a 32-bit read with a 4-byte address, about 300 cycles
  localparam int       NUM_REQS = 22;
  localparam int       MAX_CYCLES = NUM_REQS * 400;

  logic                    clk_i;
  logic                    rst_i;
  logic                    req_valid_i;
  logic                    req_ready_o;
  spi_flash_pkg::spi_req_t req_i;
  logic                    rsp_valid_o;
  logic                    rsp_ready_i;
  spi_flash_pkg::spi_rsp_t rsp_o;
  logic                    sclk_o;
  logic                    ss_n_o;
  logic [3:0]              dq_i;
  logic [3:0]              dq_o;
  logic [3:0]              dq_oe_o;

  integer                  seed = 32'h6b97_cc05;
  int                      cycles = 0;
  logic [7:0]              mem_copy [MEM_BYTES];
  spi_flash_pkg::spi_rsp_t exp_q [$];

  spi_flash_top #(
    .CLKS_PER_HALF_SCLK(CLKS_PER_HALF_SCLK),
    .CPOL(CPOL),
    .CPHA(CPHA),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) UUT (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_i(req_i),
    .rsp_valid_o(rsp_valid_o),
    .rsp_ready_i(rsp_ready_i),
    .rsp_o(rsp_o),
    .sclk_o(sclk_o),
    .ss_n_o(ss_n_o),
    .dq_i(dq_i),
    .dq_o(dq_o),
    .dq_oe_o(dq_oe_o)
  );

  flash_model #(
    .MEM_BYTES(MEM_BYTES),
    .FILL_XOR(FILL_XOR)
  ) u_flash (
    .sclk_i(sclk_o),
    .ss_n_i(ss_n_o),
    .host_dq_i(dq_o),
    .host_oe_i(dq_oe_o),
    .line_o(dq_i)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  // Command table of the supported flash opcodes
  function automatic spi_flash_pkg::spi_req_t make_req(input logic [7:0] opc,
                                                       input logic [31:0] addr,
                                                       input int nbits,
                                                       input logic [31:0] wdata);
    spi_flash_pkg::spi_req_t r;
    r            = '0;
    r.opcode     = opc;
    r.addr       = addr;
    r.addr4b     = (opc == 8'h13);
    r.has_addr   = 1'b1;
    r.dummy      = (opc == 8'h3B || opc == 8'h6B) ? 4'd8 : 4'd0;
    r.nbits      = nbits[5:0];
    r.dir        = (opc == 8'h02 || opc == 8'h32) ? spi_flash_pkg::DIR_WRITE :
                                                    spi_flash_pkg::DIR_READ;
    r.cmd_lanes  = spi_flash_pkg::LANE_SINGLE;
    r.addr_lanes = spi_flash_pkg::LANE_SINGLE;
    case (opc)
      8'h3B:        r.data_lanes = spi_flash_pkg::LANE_DUAL;
      8'h6B, 8'h32: r.data_lanes = spi_flash_pkg::LANE_QUAD;
      default:      r.data_lanes = spi_flash_pkg::LANE_SINGLE;
    endcase
    r.wdata      = wdata;
    return r;
  endfunction

  // Expected response from the memory copy, then the valid/ready handshake
  task automatic send_req(input spi_flash_pkg::spi_req_t r);
    spi_flash_pkg::spi_rsp_t exp;
    logic [31:0]             word;
    bit                      accepted;
    int                      i;
    exp.opcode = r.opcode;
    exp.rdata  = '0;
    word       = '0;
    if (r.dir == spi_flash_pkg::DIR_WRITE) begin
      for (i = 0; i < r.nbits / 8; i++) begin
        mem_copy[(r.addr + i) % MEM_BYTES] = r.wdata >> (r.nbits - 8 * (i + 1));
      end
    end else begin
      for (i = 0; i < 4; i++) begin
        word = {word[23:0], mem_copy[(r.addr + i) % MEM_BYTES]};
      end
      exp.rdata = word >> (32 - r.nbits);
    end
    exp_q.push_back(exp);
    req_i       = r;
    req_valid_i = 1'b1;
    accepted    = 1'b0;
    while (!accepted) begin
      accepted = req_ready_o;
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Compare each response as it leaves the queue
  always @(negedge clk_i) begin
    spi_flash_pkg::spi_rsp_t exp;
    if (!rst_i && rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("A response arrived with no request outstanding");
        abort_run();
      end else begin
        exp = exp_q.pop_front();
        a_rsp_match: assert (rsp_o === exp)
          else report_mismatch($sformatf("opcode %h rdata %h, expected opcode %h rdata %h",
                                         rsp_o.opcode, rsp_o.rdata, exp.opcode, exp.rdata));
      end
    end
  end

  a_sclk_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    ss_n_o |-> (sclk_o == 1'(CPOL)))
    else report_mismatch("sclk_o left its idle level while ss_n_o was high");

  a_upper_released: assert property (@(posedge clk_i) disable iff (rst_i)
    ss_n_o |-> (dq_oe_o[3:2] == 2'b00))
    else report_mismatch("DQ2 or DQ3 driven while ss_n_o was high");

  a_rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else report_mismatch("response changed or vanished before it was taken");

  // Master posts a response only into a free slot
  a_no_drop: assert property (@(posedge clk_i) disable iff (rst_i)
    UUT.mrsp_valid |-> UUT.mrsp_ready)
    else report_mismatch("response pushed into a full response queue");

  always @(posedge clk_i) begin
    cycles++;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] wdata;
    int          nbits;
    int          i;
    for (i = 0; i < MEM_BYTES; i++) begin
      mem_copy[i] = i[7:0] ^ FILL_XOR;
    end
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    a_reset_state: assert (ss_n_o && !rsp_valid_o && req_ready_o &&
                           dq_oe_o == 4'b0001 && sclk_o == 1'(CPOL))
      else report_mismatch("outputs not idle after reset");

    // Single-lane reads of any length
    for (i = 0; i < 3; i++) begin
      addr  = $random(seed);
      nbits = 8 + ($unsigned($random(seed)) % 25);
      send_req(make_req(8'h03, addr, nbits, '0));
    end
    wait_drained();

    // Same address on one, two and four lanes
    for (i = 0; i < 2; i++) begin
      addr  = $random(seed);
      nbits = 8 + 4 * ($unsigned($random(seed)) % 7);
      send_req(make_req(8'h03, addr, nbits, '0));
      send_req(make_req(8'h3B, addr, nbits, '0));
      send_req(make_req(8'h6B, addr, nbits, '0));
    end

    // Program with one lane width, read back with the other
    addr  = $random(seed);
    nbits = 8 * (1 + $unsigned($random(seed)) % 4);
    wdata = $random(seed);
    send_req(make_req(8'h32, addr, nbits, wdata));
    send_req(make_req(8'h03, addr, nbits, '0));
    addr  = $random(seed);
    nbits = 8 * (1 + $unsigned($random(seed)) % 4);
    wdata = $random(seed);
    send_req(make_req(8'h02, addr, nbits, wdata));
    send_req(make_req(8'h6B, addr, nbits, '0));

    addr = $random(seed);
    send_req(make_req(8'h13, addr, 32, '0));
    wait_drained();

    // Back-pressure fills both queues
    rsp_ready_i = 1'b0;
    for (i = 0; i < 2 * QUEUE_DEPTH; i++) begin
      addr  = $random(seed);
      nbits = 8 + ($unsigned($random(seed)) % 25);
      send_req(make_req(8'h03, addr, nbits, '0));
    end
    while (req_ready_o || UUT.mrsp_ready) begin
      @(posedge clk_i);
      #1;
    end
    rsp_ready_i = 1'b1;
    wait_drained();

    repeat (4) @(posedge clk_i);
    if (rsp_valid_o || exp_q.size() != 0) begin
      $display("Responses left over at the end of the run");
      abort_run();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: sources.f
src/spi_flash_pkg.sv
src/spi_queue.sv
src/sclk_gen.sv
src/frame_planner.sv
src/lane_shifter.sv
src/spi_flash_master.sv
src/spi_flash_top.sv
dv/flash_model.sv
dv/tb_spi_flash.sv
